// ==== tb/acq_stim.txt ====
# name wr init_num(hex) tag(hex) muon_bursts laser_bursts ped_bursts enables(bin) abort_after
#   exp_words exp_header_fill_num(hex), enables are {acq_enable1, acq_enable0}
muon_basic      0 000000 1a2b 2 3 1 01 0 9  000000
laser_basic     0 000000 1a2b 2 3 1 10 0 13 000001
ped_basic       0 000000 1a2b 2 3 1 11 0 5  000002
load_num        1 00abcd 0c0d 2 3 1 01 0 9  00abcd
muon_zero       0 000000 0c0d 0 3 1 01 0 1  00abce
disabled        0 000000 0c0d 2 3 1 00 0 0  00abcf
disabled_load   1 123456 0c0d 2 3 1 00 0 0  123456
laser_abort     0 000000 7e57 2 3 1 10 6 6  123456
laser_retry     0 000000 7e57 2 3 1 10 0 13 123456
ped_abort_hdr   0 000000 7e57 2 3 1 11 1 1  123457
ped_wrap        1 ffffff 0001 2 3 1 11 0 5  ffffff
muon_long       0 000000 ffff 6 0 0 01 0 25 000000
laser_zero      0 000000 ffff 6 0 0 10 0 1  000001
ped_one         0 000000 beef 0 0 1 11 0 5  000002
muon_abort_late 0 000000 beef 2 0 1 01 8 8  000003
muon_after      0 000000 beef 2 0 1 01 0 9  000003

// ==== list.f ====
source/acq_pkg.sv
source/fill_sequencer.sv
source/burst_counter.sv
source/sample_packer.sv
source/fill_header_gen.sv
source/adc_acq_top.sv
tb/adc_acq_top_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -sv --top-module adc_acq_top_tb -f list.f -Mdir obj_dir
	./obj_dir/Vadc_acq_top_tb | tee /dev/stderr | grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== tb/adc_acq_top_tb.sv ====
module adc_acq_top_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                 adc_clk;
    logic                 rst_n;
    acq_pkg::adc_sample_t sample;
    acq_pkg::acq_cfg_t    cfg;
    logic [23:0]          initial_fill_num;
    logic                 initial_fill_num_wr;
    logic                 acq_enable0;
    logic                 acq_enable1;
    logic                 acq_trig;
    logic                 acq_reset;
    acq_pkg::acq_out_t    acq_out;
    logic [23:0]          fill_num;
    logic                 acq_done;

    logic [127:0] got_q[$];       // valid words of the current fill
    int           done_cnt;       // acq_done pulses in the current fill
    int           cyc;            // falling edges seen so far
    int           last_word_cyc;  // cycle of the latest valid word
    int           done_cyc;       // cycle of the latest acq_done pulse
    int           errors;
    int           tests_ok;
    int           tests_bad;
    logic [31:0]  lcg_state;
    logic [11:0]  ramp;           // value driven on the next falling edge

    // fields of one stimulus line
    logic [8*24-1:0] tname;
    int              wr;
    logic [23:0]     init_num;
    logic [15:0]     tag;
    logic [20:0]     mb;
    logic [20:0]     lb;
    logic [20:0]     pb;
    logic [1:0]      en;      // {acq_enable1, acq_enable0}
    int              abort_n;
    int              exp_words;
    logic [23:0]     exp_num;

    adc_acq_top i_adc_acq_top (.*);

    initial begin
        adc_clk = 1'b0;
        forever #5 adc_clk = ~adc_clk;                     // 100 MHz
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // sample the outputs before driving the next sample
    task automatic tick();
        @(negedge adc_clk);
        cyc++;
        if (acq_out.valid) begin
            got_q.push_back(acq_out.dat);
            last_word_cyc = cyc;
        end
        if (acq_done) begin
            done_cnt++;
            done_cyc = cyc;
        end
        sample.value = ramp;
        sample.ovr   = (ramp[11:10] == 2'b11);            // over-range in the top quarter
        ramp         = ramp + 12'd1;
    endtask

    task automatic wait_words(input int n, input int limit, input string what);
        int t;
        t = 0;
        while (got_q.size() < n && t < limit) begin
            tick();
            t++;
        end
        assert (got_q.size() >= n) else begin
            $display("timeout in %0s while waiting for %0s", tname, what);
            errors++;
        end
    endtask

    function automatic logic [127:0] expect_header(input logic [1:0]  ftype,
                                                   input logic [23:0] num,
                                                   input logic [15:0] ctag,
                                                   input logic [20:0] nb);
        acq_pkg::acq_header_t h;
        h             = '0;                                // pad fields stay zero
        h.mark        = 8'hf1;
        h.fill_type   = acq_pkg::fill_type_e'(ftype);
        h.fill_num    = num;
        h.channel_tag = ctag;
        h.num_bursts  = nb;
        return h;
    endfunction

    // header word followed by lanes counting up across all data words
    task automatic check_fill(input logic [127:0] exp_hdr);
        logic [11:0] prev;
        logic [11:0] exp_v;
        logic [15:0] exp_lane;
        logic [15:0] ln;
        if (got_q.size() > 0) begin
            assert (got_q[0] == exp_hdr) else begin
                $display("MISMATCH acq_out.dat header: got %h expected %h", got_q[0], exp_hdr);
                errors++;
            end
        end
        prev = (got_q.size() > 1) ? got_q[1][11:0] - 12'd1 : 12'd0;  // first lane is free
        for (int w = 1; w < got_q.size(); w++) begin
            for (int l = 0; l < 8; l++) begin
                ln       = got_q[w][l*16 +: 16];
                exp_v    = prev + 12'd1;                   // wraps at 4096
                exp_lane = {exp_v[11:10] == 2'b11, 3'b000, exp_v};
                assert (ln == exp_lane) else begin
                    $display("MISMATCH acq_out.dat word %0d lane %0d: got %h expected %h",
                             w, l, ln, exp_lane);
                    errors++;
                end
                prev = ln[11:0];                           // resync after a bad lane
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one fill per stimulus line
    //////////////////////////////////////////////////////////////////////

    task automatic run_test();
        int          errors_before;
        int          t;
        int          toggled;
        int          exp_done;
        logic [20:0] bursts;
        logic [23:0] exp_after;
        errors_before = errors;
        toggled       = 0;
        got_q.delete();
        done_cnt  = 0;
        lcg_state = lcg_next(lcg_state);
        ramp      = lcg_state[27:16];                      // new ramp start
        case (en)
            2'b01:   bursts = mb;
            2'b10:   bursts = lb;
            2'b11:   bursts = pb;
            default: bursts = '0;
        endcase
        cfg.channel_tag      = tag;
        cfg.num_muon_bursts  = mb;
        cfg.num_laser_bursts = lb;
        cfg.num_ped_bursts   = pb;
        {acq_enable1, acq_enable0} = en;
        if (wr != 0) begin
            initial_fill_num    = init_num;
            initial_fill_num_wr = 1'b1;                    // one-cycle strobe
            tick();
            initial_fill_num_wr = 1'b0;
        end
        tick();
        acq_trig = 1'b1;                                   // held high through the fill
        if (en != 2'b00) wait_words(1, 10, "the header word");
        if (abort_n > 0) begin
            wait_words(abort_n, abort_n * 8 + 10, "words before the abort");
            acq_reset = 1'b1;
            tick();
            acq_reset = 1'b0;
        end else if (en != 2'b00) begin
            t = 0;
            while (done_cnt == 0 && t < exp_words * 8 + 20) begin
                tick();
                t++;
                if (got_q.size() == 2 && toggled == 0) begin
                    acq_trig = 1'b0;                       // drop mid fill
                    toggled  = 1;
                end else if (got_q.size() == 3 && toggled == 1) begin
                    acq_trig = 1'b1;                       // re-raise that must be ignored
                    toggled  = 2;
                end
            end
            assert (done_cnt > 0) else begin
                $display("timeout in %0s while waiting for acq_done", tname);
                errors++;
            end
        end
        repeat (40) tick();                                // trigger still high so no new fill
        acq_trig = 1'b0;
        tick();
        check_fill(expect_header(en, exp_num, tag, bursts));
        exp_done  = (abort_n == 0 && en != 2'b00) ? 1 : 0;
        exp_after = (exp_done == 1) ? exp_num + 24'd1 : exp_num;
        assert (got_q.size() == exp_words) else begin
            $display("MISMATCH valid word count: got %0h expected %0h", got_q.size(), exp_words);
            errors++;
        end
        assert (done_cnt == exp_done) else begin
            $display("MISMATCH acq_done pulses: got %0h expected %0h", done_cnt, exp_done);
            errors++;
        end
        if (exp_done == 1 && done_cnt == 1) begin
            assert (done_cyc == last_word_cyc + 1) else begin
                $display("acq_done came %0d cycles after the last valid word instead of 1",
                         done_cyc - last_word_cyc);
                errors++;
            end
        end
        assert (fill_num == exp_after) else begin
            $display("MISMATCH fill_num: got %h expected %h", fill_num, exp_after);
            errors++;
        end
        if (errors == errors_before) begin
            tests_ok++;
            $display("%0s: ok, %0d words", tname, got_q.size());
        end else begin
            tests_bad++;
            $display("%0s: error", tname);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int    fd;
        int    n;
        string line;
        errors        = 0;
        tests_ok      = 0;
        tests_bad     = 0;
        cyc           = 0;
        last_word_cyc = 0;
        done_cyc      = 0;
        lcg_state = 32'h82f9d060;
        ramp      = 12'd0;
        rst_n               = 1'b0;
        sample              = '0;
        cfg                 = '0;
        initial_fill_num    = '0;
        initial_fill_num_wr = 1'b0;
        acq_enable0         = 1'b0;
        acq_enable1         = 1'b0;
        acq_trig            = 1'b0;
        acq_reset           = 1'b0;
        repeat (5) tick();                                 // five reset edges
        rst_n = 1'b1;
        tick();
        assert (!acq_out.valid) else begin
            $display("MISMATCH acq_out.valid after reset: got %h expected %h",
                     acq_out.valid, 1'b0);
            errors++;
        end
        assert (!acq_done) else begin
            $display("MISMATCH acq_done after reset: got %h expected %h", acq_done, 1'b0);
            errors++;
        end
        assert (fill_num == 24'd0) else begin
            $display("MISMATCH fill_num after reset: got %h expected %h", fill_num, 24'd0);
            errors++;
        end
        fd = $fopen("tb/acq_stim.txt", "r");
        assert (fd != 0) else begin
            $display("could not open tb/acq_stim.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") continue;  // blank or column notes
            n = $sscanf(line, "%s %d %h %h %d %d %d %b %d %d %h", tname, wr, init_num, tag,
                        mb, lb, pb, en, abort_n, exp_words, exp_num);
            assert (n == 11) else begin
                $display("stimulus line could not be read: %0s", line);
                errors++;
            end
            if (n == 11) run_test();
        end
        if (fd != 0) $fclose(fd);
        $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (errors == 0 && tests_ok > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== source/adc_acq_top.sv ====
module adc_acq_top (
    input  logic                            adc_clk,
    input  logic                            rst_n,
    input  acq_pkg::adc_sample_t            sample,               // adc value and over-range
    input  acq_pkg::acq_cfg_t               cfg,                  // tag and burst counts
    input  logic [acq_pkg::fill_num_w-1:0]  initial_fill_num,
    input  logic                            initial_fill_num_wr,
    input  logic                            acq_enable0,          // fill type, low bit
    input  logic                            acq_enable1,          // fill type, high bit
    input  logic                            acq_trig,
    input  logic                            acq_reset,
    output acq_pkg::acq_out_t               acq_out,              // to the fifo
    output logic [acq_pkg::fill_num_w-1:0]  fill_num,
    output logic                            acq_done
);

    acq_pkg::fill_type_e          fill_type;
    acq_pkg::acq_header_t         header;
    logic [acq_pkg::word_w-1:0]   packed_word;
    logic [acq_pkg::burst_w-1:0]  num_bursts;
    logic                         header_load;
    logic                         packer_clear;
    logic                         word_step;
    logic                         word_ready;
    logic                         last_word;
    logic                         empty_fill;
    logic                         idle;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    fill_sequencer i_fill_sequencer (
        .adc_clk      (adc_clk),
        .rst_n        (rst_n),
        .acq_trig     (acq_trig),
        .acq_enable0  (acq_enable0),
        .acq_enable1  (acq_enable1),
        .acq_reset    (acq_reset),
        .header       (header),
        .packed_word  (packed_word),
        .word_ready   (word_ready),
        .last_word    (last_word),
        .empty_fill   (empty_fill),
        .fill_type    (fill_type),
        .header_load  (header_load),
        .packer_clear (packer_clear),
        .word_step    (word_step),
        .fill_done    (acq_done),       // completion pulse goes straight out
        .idle         (idle),
        .acq_out      (acq_out)
    );

    burst_counter i_burst_counter (
        .adc_clk    (adc_clk),
        .rst_n      (rst_n),
        .clear      (header_load),      // counts restart with every fill
        .word_step  (word_step),
        .num_bursts (num_bursts),
        .last_word  (last_word),
        .empty_fill (empty_fill)
    );

    //////////////////////////////////////////////////////////////////////
    // data path
    //////////////////////////////////////////////////////////////////////

    sample_packer i_sample_packer (
        .adc_clk     (adc_clk),
        .rst_n       (rst_n),
        .clear       (packer_clear),
        .sample      (sample),
        .word_ready  (word_ready),
        .packed_word (packed_word)
    );

    fill_header_gen i_fill_header_gen (
        .adc_clk             (adc_clk),
        .rst_n               (rst_n),
        .cfg                 (cfg),
        .fill_type           (fill_type),
        .header_load         (header_load),
        .initial_fill_num    (initial_fill_num),
        .initial_fill_num_wr (initial_fill_num_wr),
        .idle                (idle),
        .fill_done           (acq_done),
        .num_bursts          (num_bursts),
        .header              (header),
        .fill_num            (fill_num)
    );

endmodule

// ==== source/fill_header_gen.sv ====
module fill_header_gen (
    input  logic                            adc_clk,
    input  logic                            rst_n,
    input  acq_pkg::acq_cfg_t               cfg,
    input  acq_pkg::fill_type_e             fill_type,
    input  logic                            header_load,          // fill start
    input  logic [acq_pkg::fill_num_w-1:0]  initial_fill_num,
    input  logic                            initial_fill_num_wr,  // one-cycle strobe
    input  logic                            idle,                 // sequencer idle
    input  logic                            fill_done,            // fill completed
    output logic [acq_pkg::burst_w-1:0]     num_bursts,           // held for the fill
    output acq_pkg::acq_header_t            header,
    output logic [acq_pkg::fill_num_w-1:0]  fill_num
);

    logic [acq_pkg::burst_w-1:0]    bursts_sel;   // burst count for the requested type
    logic [acq_pkg::fill_num_w-1:0] fill_num_q;

    always_comb begin
        case (fill_type)
            acq_pkg::fill_muon:  bursts_sel = cfg.num_muon_bursts;
            acq_pkg::fill_laser: bursts_sel = cfg.num_laser_bursts;
            acq_pkg::fill_ped:   bursts_sel = cfg.num_ped_bursts;
            default:             bursts_sel = '0;
        endcase
    end

    // fill number, a write only lands between fills
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            fill_num_q <= '0;
        end else if (idle && initial_fill_num_wr) begin
            fill_num_q <= initial_fill_num;
        end else if (fill_done) begin
            fill_num_q <= fill_num_q + 1'b1;               // aborted fills never get here
        end
    end

    // header and burst count captured together at fill start
    always_ff @(posedge adc_clk) begin
        if (header_load) begin
            num_bursts         <= bursts_sel;
            header.mark        <= acq_pkg::header_mark;
            header.fill_type   <= fill_type;
            header.pad         <= '0;
            header.fill_num    <= fill_num_q;
            header.channel_tag <= cfg.channel_tag;
            header.num_bursts  <= bursts_sel;
            header.zero        <= '0;
        end
    end

    assign fill_num = fill_num_q;

endmodule

// ==== source/sample_packer.sv ====
module sample_packer (
    input  logic                          adc_clk,
    input  logic                          rst_n,
    input  logic                          clear,        // next sample goes to lane 0
    input  acq_pkg::adc_sample_t          sample,       // new sample every edge
    output logic                          word_ready,   // one-cycle pulse
    output logic [acq_pkg::word_w-1:0]    packed_word
);

    logic [acq_pkg::lane_w-1:0]     lane;         // current sample as a lane
    logic [acq_pkg::hold_w-1:0]     shift_q;      // last seven lanes, oldest lowest
    logic [acq_pkg::lane_idx_w-1:0] lane_idx_q;   // lane of the current sample
    logic                           last_lane;
    logic                           word_ready_q;
    logic [acq_pkg::word_w-1:0]     word_q;

    //////////////////////////////////////////////////////////////////////
    // lane format and shift register
    //////////////////////////////////////////////////////////////////////

    // ovr on top, reserved bits zero, value in the low bits
    assign lane = {sample.ovr,
                   {(acq_pkg::lane_w - acq_pkg::samp_w - 1){1'b0}},
                   sample.value};

    assign last_lane = (lane_idx_q == acq_pkg::lane_idx_w'(acq_pkg::samples_per_word - 1));

    // new lane in at the top, so the oldest sample ends up in lane 0
    always_ff @(posedge adc_clk) begin
        shift_q <= {lane, shift_q[acq_pkg::hold_w-1:acq_pkg::lane_w]};
    end

    // completed word, lane 7 taken straight from the input
    always_ff @(posedge adc_clk) begin
        if (last_lane && !clear) begin
            word_q <= {lane, shift_q};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // lane index and ready pulse
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            lane_idx_q   <= '0;
            word_ready_q <= 1'b0;
        end else begin
            if (clear) begin
                lane_idx_q <= acq_pkg::lane_idx_w'(1);     // sample on this edge is lane 0
            end else begin
                lane_idx_q <= lane_idx_q + 1'b1;           // wraps 7 -> 0
            end
            word_ready_q <= last_lane && !clear;
        end
    end

    assign word_ready  = word_ready_q;
    assign packed_word = word_q;

endmodule

// ==== source/burst_counter.sv ====
module burst_counter (
    input  logic                          adc_clk,
    input  logic                          rst_n,
    input  logic                          clear,       // fill start
    input  logic                          word_step,   // one data word sent
    input  logic [acq_pkg::burst_w-1:0]   num_bursts,  // latched for this fill
    output logic                          last_word,
    output logic                          empty_fill
);

    logic [acq_pkg::word_idx_w-1:0] word_idx_q;   // word within the burst
    logic [acq_pkg::burst_w-1:0]    burst_idx_q;  // burst within the fill
    logic                           word_wrap;    // last word of a burst

    assign word_wrap = (word_idx_q == acq_pkg::word_idx_w'(acq_pkg::burst_words - 1));

    //////////////////////////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            word_idx_q  <= '0;
            burst_idx_q <= '0;
        end else if (clear) begin
            word_idx_q  <= '0;
            burst_idx_q <= '0;
        end else if (word_step) begin
            if (word_wrap) begin
                word_idx_q  <= '0;
                burst_idx_q <= burst_idx_q + 1'b1;         // next burst
            end else begin
                word_idx_q <= word_idx_q + 1'b1;
            end
        end
    end

    // final word of the final burst
    assign last_word = word_wrap
                       && (burst_idx_q == num_bursts - acq_pkg::burst_w'(1));

    // nothing after the header, the fsm skips its data state
    assign empty_fill = (num_bursts == '0);

endmodule

// ==== source/fill_sequencer.sv ====
module fill_sequencer (
    input  logic                          adc_clk,
    input  logic                          rst_n,
    input  logic                          acq_trig,      // level trigger whose edge starts a fill
    input  logic                          acq_enable0,
    input  logic                          acq_enable1,
    input  logic                          acq_reset,     // abort the current fill
    input  acq_pkg::acq_header_t          header,        // from fill_header_gen
    input  logic [acq_pkg::word_w-1:0]    packed_word,   // from sample_packer
    input  logic                          word_ready,
    input  logic                          last_word,     // from burst_counter
    input  logic                          empty_fill,    // zero bursts programmed
    output acq_pkg::fill_type_e           fill_type,
    output logic                          header_load,
    output logic                          packer_clear,
    output logic                          word_step,
    output logic                          fill_done,
    output logic                          idle,
    output acq_pkg::acq_out_t             acq_out
);

    typedef enum logic [1:0] {
        st_idle,    // waiting for a trigger edge
        st_header,  // header on the output
        st_data,    // forwarding packed words
        st_done     // one-cycle completion pulse
    } state_e;

    state_e              state_q;
    state_e              state_d;
    logic                trig_q;        // previous acq_trig
    logic                trig_edge;
    acq_pkg::fill_type_e enable_type;   // type requested by the enables

    //////////////////////////////////////////////////////////////////////
    // trigger and control pulses
    //////////////////////////////////////////////////////////////////////

    assign enable_type = acq_pkg::fill_type_e'({acq_enable1, acq_enable0});
    assign trig_edge   = acq_trig && !trig_q;             // rising edge only
    assign idle        = (state_q == st_idle);

    // fill start with the header registered on this edge
    assign header_load = idle && trig_edge && !acq_reset
                         && (enable_type != acq_pkg::fill_none);

    assign packer_clear = (state_q == st_header);          // first sample on next edge
    assign word_step    = (state_q == st_data) && word_ready;
    assign fill_done    = (state_q == st_done);

    assign fill_type = enable_type;                        // latched by header_gen on header_load

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        if (acq_reset) begin
            state_d = st_idle;                             // abort wins over everything
        end else begin
            case (state_q)
                st_idle:   if (header_load) state_d = st_header;
                st_header: state_d = empty_fill ? st_done : st_data;  // header-only fill
                st_data:   if (word_step && last_word) state_d = st_done;
                st_done:   state_d = st_idle;
                default:   state_d = st_idle;
            endcase
        end
    end

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
            trig_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            trig_q  <= acq_trig;                           // tracks during fills too
        end
    end

    // output select with valid set only by the fsm
    always_comb begin
        acq_out.valid = 1'b0;
        acq_out.dat   = packed_word;
        case (state_q)
            st_header: begin
                acq_out.valid = 1'b1;
                acq_out.dat   = header;
            end
            st_data:   acq_out.valid = word_ready;
            default:   acq_out.valid = 1'b0;
        endcase
    end

endmodule

// ==== source/acq_pkg.sv ====
package acq_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and counts
    //////////////////////////////////////////////////////////////////////

    localparam int samp_w           = 12;   // adc sample value bits
    localparam int lane_w           = 16;   // one sample lane in a data word
    localparam int samples_per_word = 8;    // lanes per data word
    localparam int word_w           = 128;  // fifo word width
    localparam int burst_w          = 21;   // burst count width
    localparam int fill_num_w       = 24;   // fill number width
    localparam int tag_w            = 16;   // channel tag width
    localparam int burst_words      = 4;    // data words per burst

    localparam logic [7:0] header_mark = 8'hf1;  // top byte of every header

    localparam int lane_idx_w = $clog2(samples_per_word);     // packer lane index
    localparam int word_idx_w = $clog2(burst_words);          // word-in-burst index
    localparam int hold_w     = (samples_per_word - 1) * lane_w;  // lanes held before last
    // header bits left over below num_bursts
    localparam int hdr_pad_w  = word_w - 8 - 2 - 6 - fill_num_w - tag_w - burst_w;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    // {acq_enable1, acq_enable0}
    typedef enum logic [1:0] {
        fill_none  = 2'd0,  // disabled, triggers ignored
        fill_muon  = 2'd1,
        fill_laser = 2'd2,
        fill_ped   = 2'd3   // pedestal
    } fill_type_e;

    typedef struct packed {
        logic [tag_w-1:0]   channel_tag;       // copied into every header
        logic [burst_w-1:0] num_muon_bursts;
        logic [burst_w-1:0] num_laser_bursts;
        logic [burst_w-1:0] num_ped_bursts;
    } acq_cfg_t;

    typedef struct packed {
        logic [7:0]            mark;         // always header_mark
        fill_type_e            fill_type;
        logic [5:0]            pad;          // zero
        logic [fill_num_w-1:0] fill_num;
        logic [tag_w-1:0]      channel_tag;
        logic [burst_w-1:0]    num_bursts;   // bursts that follow this header
        logic [hdr_pad_w-1:0]  zero;
    } acq_header_t;

    typedef struct packed {
        logic              ovr;    // over-range flag from the adc
        logic [samp_w-1:0] value;
    } adc_sample_t;

    typedef struct packed {
        logic              valid;  // write enable for the fifo
        logic [word_w-1:0] dat;    // header or packed samples
    } acq_out_t;

endpackage
